// File: cart/cart_loader.sv
// Cartridge download and bank mapping

`timescale 1ns/1ps
`include "vp_macros.svh"

module cart_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  vp_pkg::dl_addr_t dl_addr_i,
	input  vp_pkg::dl_index_t dl_index_i,
	input  vp_pkg::byte_t dl_data_i,
	input  vp_pkg::cart_addr_t cart_addr_i,
	input  logic cart_bs0_i,
	input  logic cart_bs1_i,
	input  logic cart_psen_n_i,
	rom_port_if.loader rom
);

	vp_pkg::dl_state_t state;
	vp_pkg::img_size_t size;
	logic xrom;
	logic dl_start;

	//////////////////////////////////////////////////
	// Download tracking

	// Rising edge of the download window
	assign dl_start = dl_active_i & (state != vp_pkg::st_loading);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= vp_pkg::st_idle;
			size <= '0;
			xrom <= 1'b0;
		end else begin
			case (state)
				vp_pkg::st_loading: begin
					if (!dl_active_i)
						state <= vp_pkg::st_loaded;
					else if (dl_wr_i)
						size <= size + 16'd1;
				end
				default: begin
					if (dl_start) begin
						state <= vp_pkg::st_loading;
						// A byte in the first cycle counts too
						size <= {15'd0, dl_wr_i};
						xrom <= (dl_index_i == vp_pkg::dl_index_t'(`VP_IDX_XROM));
					end
				end
			endcase
		end
	end

	// Cartridge images go straight into the ROM
	assign rom.wr_en = dl_active_i & dl_wr_i &
		(dl_index_i <= vp_pkg::dl_index_t'(`VP_IDX_CART_LAST));
	assign rom.wr_addr = dl_addr_i[13:0];
	assign rom.wr_data = dl_data_i;

	// Download address inside the ROM
	assert property (@(posedge clk_sys) disable iff (reset)
		rom.wr_en |-> (dl_addr_i < vp_pkg::dl_addr_t'(`VP_ROM_DEPTH)));

	//////////////////////////////////////////////////
	// Console address decode

	// Reads pause while a download owns the ROM
	assign rom.rd_en = ~cart_psen_n_i & (state != vp_pkg::st_loading);

	always_comb begin
		if (xrom) begin
			// XROM sees the full 4K window directly
			rom.rd_addr = {2'b00, cart_addr_i};
		end else begin
			case (size)
				16'(`VP_IMG_4K):
					rom.rd_addr = {2'b00, cart_bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
				16'(`VP_IMG_8K):
					rom.rd_addr = {1'b0, cart_bs1_i, cart_bs0_i, cart_addr_i[11], cart_addr_i[9:0]};
				16'(`VP_IMG_16K):
					rom.rd_addr = {cart_bs1_i, cart_bs0_i, cart_addr_i};
				default:
					rom.rd_addr = {3'b000, cart_addr_i[11], cart_addr_i[9:0]};
			endcase
		end
	end

	// Image bigger than the ROM
	assert property (@(posedge clk_sys) disable iff (reset)
		(state == vp_pkg::st_loading) |-> (size <= 16'(`VP_IMG_16K)));

endmodule

// File: cart/cart_rom.sv
// Cartridge ROM

`timescale 1ns/1ps
`include "vp_macros.svh"

module cart_rom (
	input  logic clk_sys,
	rom_port_if.mem rom
);

	// Byte array, filled by the host download
	vp_pkg::byte_t mem [`VP_ROM_DEPTH];

	//////////////////////////////////////////////////
	// Write port

	always_ff @(posedge clk_sys) begin
		if (rom.wr_en)
			mem[rom.wr_addr] <= rom.wr_data;
	end

	//////////////////////////////////////////////////
	// Read port

	// Output holds the last byte while rd_en is low
	always_ff @(posedge clk_sys) begin
		if (rom.rd_en)
			rom.rd_data <= mem[rom.rd_addr];
	end

	// Download address known on every write
	assert property (@(posedge clk_sys)
		rom.wr_en |-> !$isunknown(rom.wr_addr));

endmodule

// File: common/rom_port_if.sv
// Cartridge ROM access port

`timescale 1ns/1ps

interface rom_port_if;

	// Download side, one byte per cycle with wr_en high
	logic wr_en;
	vp_pkg::rom_addr_t wr_addr;
	vp_pkg::byte_t wr_data;

	// Console side, data follows rd_en by one cycle
	logic rd_en;
	vp_pkg::rom_addr_t rd_addr;
	vp_pkg::byte_t rd_data;

	modport loader (
		output wr_en, wr_addr, wr_data,
		output rd_en, rd_addr
	);

	modport mem (
		input  wr_en, wr_addr, wr_data,
		input  rd_en, rd_addr,
		output rd_data
	);

endinterface

// File: common/vp_macros.svh
// Videopac host glue constants

`ifndef VP_MACROS_SVH
`define VP_MACROS_SVH

// CPU enable period in clk_sys cycles
`define VP_CPU_DIV_NTSC 8
`define VP_CPU_DIV_PAL 12

// VDC enable period in clk_sys cycles
`define VP_VDC_DIV_NTSC 6
`define VP_VDC_DIV_PAL 10

// Cartridge ROM depth in bytes
`define VP_ROM_DEPTH 16384

// Image sizes that select a bank mapping
`define VP_IMG_4K 4096
`define VP_IMG_8K 8192
`define VP_IMG_16K 16384

// Download index of an XROM image
`define VP_IDX_XROM 2

// Highest download index that goes to the cartridge ROM
`define VP_IDX_CART_LAST 2

`endif

// File: common/vp_pkg.sv
// Videopac host glue types

package vp_pkg;

	// Console cartridge address bus
	typedef logic [11:0] cart_addr_t;

	// Byte address into the cartridge ROM
	typedef logic [13:0] rom_addr_t;

	// Data byte, also used for ASCII codes
	typedef logic [7:0] byte_t;

	// Host download address and file index
	typedef logic [24:0] dl_addr_t;
	typedef logic [7:0] dl_index_t;

	// Byte count of the last downloaded image
	typedef logic [15:0] img_size_t;

	// PS/2 event word
	// Bit 10 toggles per event, bit 9 pressed, bits 8:0 extended flag and scancode
	typedef logic [10:0] ps2_key_t;

	// Host joystick word
	// Bits 3:0 up/down/left/right, 4 action, 5 reset, 15:6 keys 1..9,0
	typedef logic [15:0] joy_t;

	// Numeric keypad, bit 0 is key 1 and bit 9 is key 0
	typedef logic [9:0] pad_t;

	// Active low line pair, bit 1 first player and bit 0 second player
	typedef logic [1:0] player_pair_t;

	// Cartridge download tracking
	typedef enum logic [1:0] {
		st_idle,
		st_loading,
		st_loaded
	} dl_state_t;

endpackage

// File: compile.f
+incdir+common
common/vp_pkg.sv
common/rom_port_if.sv
hdl/clk_enables.sv
cart/cart_loader.sv
cart/cart_rom.sv
input/host_input.sv
hdl/vp_host_top.sv
tb/tb_clkgen.sv
tb/tb_vp_host.sv

// File: hdl/clk_enables.sv
// CPU and VDC clock enables

`timescale 1ns/1ps
`include "vp_macros.svh"

module clk_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Terminal counts, channel 0 is CPU and channel 1 is VDC
	localparam logic [3:0] last_ntsc [2] = '{4'(`VP_CPU_DIV_NTSC - 1), 4'(`VP_VDC_DIV_NTSC - 1)};
	localparam logic [3:0] last_pal [2] = '{4'(`VP_CPU_DIV_PAL - 1), 4'(`VP_VDC_DIV_PAL - 1)};

	logic pal_q;
	logic pal_seen;
	logic restart;
	logic [1:0] en_q;

	//////////////////////////////////////////////////
	// Video standard change detect

	// No restart on the first cycle out of reset
	assign restart = pal_seen & (pal_i != pal_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q <= 1'b0;
			pal_seen <= 1'b0;
		end else begin
			pal_q <= pal_i;
			pal_seen <= 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Divider channels

	for (genvar ch = 0; ch < 2; ch++) begin : g_div
		logic [3:0] cnt;
		logic [3:0] last;

		// Period follows the current standard
		assign last = pal_i ? last_pal[ch] : last_ntsc[ch];

		always_ff @(posedge clk_sys or posedge reset) begin
			if (reset) begin
				cnt <= 4'd0;
				en_q[ch] <= 1'b0;
			end else if (restart) begin
				// Start a fresh period
				cnt <= 4'd0;
				en_q[ch] <= 1'b0;
			end else if (cnt == last) begin
				cnt <= 4'd0;
				en_q[ch] <= 1'b1;
			end else begin
				cnt <= cnt + 4'd1;
				en_q[ch] <= 1'b0;
			end
		end

		// Pulses stay one cycle wide, even across a standard change
		assert property (@(posedge clk_sys) disable iff (reset) en_q[ch] |=> !en_q[ch]);
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

// File: hdl/vp_host_top.sv
// Videopac host glue top level

`timescale 1ns/1ps

module vp_host_top (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o,
	// Host download
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  vp_pkg::dl_addr_t dl_addr_i,
	input  vp_pkg::dl_index_t dl_index_i,
	input  vp_pkg::byte_t dl_data_i,
	// Console cartridge bus
	input  vp_pkg::cart_addr_t cart_addr_i,
	input  logic cart_bs0_i,
	input  logic cart_bs1_i,
	input  logic cart_psen_n_i,
	output vp_pkg::byte_t cart_data_o,
	// Host controls
	input  vp_pkg::joy_t joy0_i,
	input  vp_pkg::joy_t joy1_i,
	input  logic swap_i,
	input  vp_pkg::ps2_key_t ps2_key_i,
	output vp_pkg::player_pair_t joy_up_n_o,
	output vp_pkg::player_pair_t joy_down_n_o,
	output vp_pkg::player_pair_t joy_left_n_o,
	output vp_pkg::player_pair_t joy_right_n_o,
	output vp_pkg::player_pair_t joy_action_n_o,
	output logic console_reset_n_o,
	output logic key_valid_o,
	output vp_pkg::byte_t key_ascii_o,
	output logic key_released_o
);

	// Loader to ROM link
	rom_port_if rom_if ();

	clk_enables u_clk_enables (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	//////////////////////////////////////////////////
	// Cartridge

	cart_loader u_cart_loader (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active_i   (dl_active_i),
		.dl_wr_i       (dl_wr_i),
		.dl_addr_i     (dl_addr_i),
		.dl_index_i    (dl_index_i),
		.dl_data_i     (dl_data_i),
		.cart_addr_i   (cart_addr_i),
		.cart_bs0_i    (cart_bs0_i),
		.cart_bs1_i    (cart_bs1_i),
		.cart_psen_n_i (cart_psen_n_i),
		.rom           (rom_if.loader)
	);

	cart_rom u_cart_rom (
		.clk_sys (clk_sys),
		.rom     (rom_if.mem)
	);

	// Registered ROM byte goes straight to the console
	assign cart_data_o = rom_if.rd_data;

	//////////////////////////////////////////////////
	// Input

	host_input u_host_input (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.joy0_i            (joy0_i),
		.joy1_i            (joy1_i),
		.swap_i            (swap_i),
		.ps2_key_i         (ps2_key_i),
		.joy_up_n_o        (joy_up_n_o),
		.joy_down_n_o      (joy_down_n_o),
		.joy_left_n_o      (joy_left_n_o),
		.joy_right_n_o     (joy_right_n_o),
		.joy_action_n_o    (joy_action_n_o),
		.console_reset_n_o (console_reset_n_o),
		.key_valid_o       (key_valid_o),
		.key_ascii_o       (key_ascii_o),
		.key_released_o    (key_released_o)
	);

endmodule

// File: input/host_input.sv
// Joystick and keyboard input

`timescale 1ns/1ps

module host_input (
	input  logic clk_sys,
	input  logic reset,
	input  vp_pkg::joy_t joy0_i,
	input  vp_pkg::joy_t joy1_i,
	input  logic swap_i,
	input  vp_pkg::ps2_key_t ps2_key_i,
	output vp_pkg::player_pair_t joy_up_n_o,
	output vp_pkg::player_pair_t joy_down_n_o,
	output vp_pkg::player_pair_t joy_left_n_o,
	output vp_pkg::player_pair_t joy_right_n_o,
	output vp_pkg::player_pair_t joy_action_n_o,
	output logic console_reset_n_o,
	output logic key_valid_o,
	output vp_pkg::byte_t key_ascii_o,
	output logic key_released_o
);

	// Scancode to ASCII, extended flag ignored
	function automatic vp_pkg::byte_t ps2_ascii(input logic [7:0] code);
		case (code)
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			// GUI keys act as yes and no
			8'h1F: return 8'h11;
			8'h27: return 8'h12;
			8'h5A: return 8'h0A;
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

	// Lowest pressed key wins, zero when none
	function automatic vp_pkg::byte_t pad_ascii(input vp_pkg::pad_t pad);
		vp_pkg::byte_t code;
		code = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i])
				code = (i == 9) ? "0" : 8'("1" + i);
		end
		return code;
	endfunction

	vp_pkg::joy_t joy_a;
	vp_pkg::joy_t joy_b;
	vp_pkg::pad_t pad;
	vp_pkg::pad_t pad_q;
	logic toggle_q;
	logic ps2_event;
	logic pad_event;

	//////////////////////////////////////////////////
	// Joysticks

	assign joy_a = swap_i ? joy1_i : joy0_i;
	assign joy_b = swap_i ? joy0_i : joy1_i;

	// Console lines are low when pressed
	assign joy_right_n_o = {~joy_a[0], ~joy_b[0]};
	assign joy_left_n_o = {~joy_a[1], ~joy_b[1]};
	assign joy_down_n_o = {~joy_a[2], ~joy_b[2]};
	assign joy_up_n_o = {~joy_a[3], ~joy_b[3]};
	assign joy_action_n_o = {~joy_a[4], ~joy_b[4]};
	assign console_reset_n_o = ~(joy_a[5] & joy_b[5]);

	//////////////////////////////////////////////////
	// Key events

	// Either player's keypad counts
	assign pad = joy_a[15:6] | joy_b[15:6];
	assign ps2_event = ps2_key_i[10] ^ toggle_q;
	assign pad_event = (pad != pad_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			pad_q <= '0;
			key_valid_o <= 1'b0;
			key_released_o <= 1'b0;
		end else begin
			toggle_q <= ps2_key_i[10];
			pad_q <= pad;
			key_valid_o <= ps2_event | pad_event;
			key_released_o <= ~ps2_key_i[9] & (pad == '0);
		end
	end

	// PS/2 has priority when both change together
	always_ff @(posedge clk_sys) begin
		if (ps2_event)
			key_ascii_o <= ps2_ascii(ps2_key_i[7:0]);
		else if (pad_event)
			key_ascii_o <= pad_ascii(pad);
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the Videopac host glue testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -f compile.f --top-module tb_vp_host -o tb_vp_host; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_vp_host > "$log" 2>&1
status=$?
cat "$log"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" "$log"; then
	echo "Simulation passed"
	exit 0
fi

echo "Pass line missing from $log"
exit 1

// File: tb/tb_clkgen.sv
// Testbench clock and reset

`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_sys_o,
	output logic reset_o
);

	// 10 ns system clock
	initial clk_sys_o = 1'b0;
	always #5 clk_sys_o = ~clk_sys_o;

	// Reset held for 16 cycles, released just after an edge
	initial begin
		reset_o = 1'b1;
		repeat (16) @(posedge clk_sys_o);
		#1;
		reset_o = 1'b0;
	end

endmodule

// File: tb/tb_vp_host.sv
// Videopac host glue testbench

`timescale 1ns/1ps
`include "vp_macros.svh"

module tb_vp_host;

	// Cycle budget, downloads plus four bank combinations of 4K reads per image
	localparam int load_cycles = `VP_IMG_4K + `VP_IMG_8K + `VP_IMG_16K + 2048 + `VP_IMG_4K;
	localparam int read_cycles = 5 * 4 * 4096;
	localparam int misc_cycles = 2000;
	localparam int test_cycles = load_cycles + read_cycles + misc_cycles;

	logic clk_sys;
	logic reset;
	logic pal;
	logic cpu_en;
	logic vdc_en;
	logic dl_active;
	logic dl_wr;
	vp_pkg::dl_addr_t dl_addr;
	vp_pkg::dl_index_t dl_index;
	vp_pkg::byte_t dl_data;
	vp_pkg::cart_addr_t cart_addr;
	logic cart_bs0;
	logic cart_bs1;
	logic cart_psen_n;
	vp_pkg::byte_t cart_data;
	vp_pkg::joy_t joy0;
	vp_pkg::joy_t joy1;
	logic swap;
	vp_pkg::ps2_key_t ps2_key;
	vp_pkg::player_pair_t joy_up_n;
	vp_pkg::player_pair_t joy_down_n;
	vp_pkg::player_pair_t joy_left_n;
	vp_pkg::player_pair_t joy_right_n;
	vp_pkg::player_pair_t joy_action_n;
	logic console_reset_n;
	logic key_valid;
	vp_pkg::byte_t key_ascii;
	logic key_released;

	// Expected ROM contents, written alongside each download
	vp_pkg::byte_t model [`VP_ROM_DEPTH];
	int seed = 32'h7b7d_28df;

	tb_clkgen u_clkgen (
		.clk_sys_o (clk_sys),
		.reset_o   (reset)
	);

	vp_host_top dut0 (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.pal_i             (pal),
		.cpu_en_o          (cpu_en),
		.vdc_en_o          (vdc_en),
		.dl_active_i       (dl_active),
		.dl_wr_i           (dl_wr),
		.dl_addr_i         (dl_addr),
		.dl_index_i        (dl_index),
		.dl_data_i         (dl_data),
		.cart_addr_i       (cart_addr),
		.cart_bs0_i        (cart_bs0),
		.cart_bs1_i        (cart_bs1),
		.cart_psen_n_i     (cart_psen_n),
		.cart_data_o       (cart_data),
		.joy0_i            (joy0),
		.joy1_i            (joy1),
		.swap_i            (swap),
		.ps2_key_i         (ps2_key),
		.joy_up_n_o        (joy_up_n),
		.joy_down_n_o      (joy_down_n),
		.joy_left_n_o      (joy_left_n),
		.joy_right_n_o     (joy_right_n),
		.joy_action_n_o    (joy_action_n),
		.console_reset_n_o (console_reset_n),
		.key_valid_o       (key_valid),
		.key_ascii_o       (key_ascii),
		.key_released_o    (key_released)
	);

	//////////////////////////////////////////////////
	// Compare helpers

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input vp_pkg::byte_t exp,
			input vp_pkg::byte_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	task automatic check_pair(input string name, input vp_pkg::player_pair_t exp,
			input vp_pkg::player_pair_t act);
		if (act !== exp)
			fail_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
	endtask

	// Cycle counts of the enable pulses
	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
			fail_run($sformatf("[ERROR] %0t %s expected %0d actual %0d", $time, name, exp, act));
	endtask

	// Inputs change 1 ns after the edge, registered outputs are settled then
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	//////////////////////////////////////////////////
	// Clock enables

	function automatic logic enable_seen(input bit use_vdc);
		return use_vdc ? vdc_en : cpu_en;
	endfunction

	// Cycles until each enable first pulses
	task automatic measure_first(output int cpu_n, output int vdc_n);
		int n;
		n = 0;
		cpu_n = 0;
		vdc_n = 0;
		while (cpu_n == 0 || vdc_n == 0) begin
			next_cycle();
			n++;
			if (cpu_en && cpu_n == 0)
				cpu_n = n;
			if (vdc_en && vdc_n == 0)
				vdc_n = n;
			if (n > 40)
				fail_run("Enable pulse missing after reset or a standard change");
		end
	endtask

	// Distance between two pulses, a wide pulse shows as a period of one
	task automatic measure_period(input bit use_vdc, output int cycles);
		int n;
		n = 0;
		while (!enable_seen(use_vdc)) begin
			next_cycle();
			n++;
			if (n > 40)
				fail_run("Enable pulse missing while measuring its period");
		end
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (!enable_seen(use_vdc) && cycles < 40);
	endtask

	task automatic check_periods(input int cpu_exp, input int vdc_exp);
		int n;
		measure_period(1'b0, n);
		check_count("cpu_en_o period", cpu_exp, n);
		measure_period(1'b1, n);
		check_count("vdc_en_o period", vdc_exp, n);
	endtask

	// Change is seen on the next edge, then one full new period follows
	task automatic switch_standard(input logic to_pal, input int cpu_period,
			input int vdc_period);
		int cpu_n;
		int vdc_n;
		pal = to_pal;
		measure_first(cpu_n, vdc_n);
		check_count("cpu_en_o after standard change", cpu_period + 1, cpu_n);
		check_count("vdc_en_o after standard change", vdc_period + 1, vdc_n);
	endtask

	task automatic test_enables();
		int cpu_n;
		int vdc_n;
		// First pulse closes the first full period after reset
		measure_first(cpu_n, vdc_n);
		check_count("cpu_en_o first pulse", `VP_CPU_DIV_NTSC, cpu_n);
		check_count("vdc_en_o first pulse", `VP_VDC_DIV_NTSC, vdc_n);
		check_periods(`VP_CPU_DIV_NTSC, `VP_VDC_DIV_NTSC);
		switch_standard(1'b1, `VP_CPU_DIV_PAL, `VP_VDC_DIV_PAL);
		check_periods(`VP_CPU_DIV_PAL, `VP_VDC_DIV_PAL);
		switch_standard(1'b0, `VP_CPU_DIV_NTSC, `VP_VDC_DIV_NTSC);
		check_periods(`VP_CPU_DIV_NTSC, `VP_VDC_DIV_NTSC);
	endtask

	//////////////////////////////////////////////////
	// Cartridge download and readback

	// One random byte per download strobe
	task automatic load_image(input vp_pkg::dl_index_t index, input int size);
		vp_pkg::byte_t value;
		int i;
		dl_index = index;
		dl_active = 1'b1;
		dl_wr = 1'b0;
		next_cycle();
		for (i = 0; i < size; i++) begin
			value = vp_pkg::byte_t'($random(seed));
			model[i] = value;
			dl_addr = vp_pkg::dl_addr_t'(i);
			dl_data = value;
			dl_wr = 1'b1;
			next_cycle();
		end
		dl_wr = 1'b0;
		dl_active = 1'b0;
		next_cycle();
		next_cycle();
	endtask

	// Bank mapping by image size
	function automatic int mapped_addr(input int size, input bit xrom, input int a,
			input bit bs0, input bit bs1);
		int low10;
		int a11;
		low10 = a % 1024;
		a11 = (a / 2048) % 2;
		if (xrom)
			return a;
		case (size)
			`VP_IMG_4K: return int'(bs0) * 2048 + a11 * 1024 + low10;
			`VP_IMG_8K: return int'(bs1) * 4096 + int'(bs0) * 2048 + a11 * 1024 + low10;
			`VP_IMG_16K: return int'(bs1) * 8192 + int'(bs0) * 4096 + a;
			default: return a11 * 1024 + low10;
		endcase
	endfunction

	// Every bank select pair over the whole 4K window
	task automatic read_back(input int size, input bit xrom);
		int bs;
		int a;
		int rom_addr;
		for (bs = 0; bs < 4; bs++) begin
			for (a = 0; a < 4096; a++) begin
				cart_addr = vp_pkg::cart_addr_t'(a);
				cart_bs0 = bs[0];
				cart_bs1 = bs[1];
				cart_psen_n = 1'b0;
				next_cycle();
				rom_addr = mapped_addr(size, xrom, a, bs[0], bs[1]);
				check_byte("cart_data_o", model[rom_addr], cart_data);
			end
		end
		cart_psen_n = 1'b1;
	endtask

	task automatic test_4k_image();
		load_image(8'd1, `VP_IMG_4K);
		read_back(`VP_IMG_4K, 1'b0);
	endtask

	task automatic test_large_images();
		load_image(8'd0, `VP_IMG_8K);
		read_back(`VP_IMG_8K, 1'b0);
		load_image(8'd1, `VP_IMG_16K);
		read_back(`VP_IMG_16K, 1'b0);
		// Odd size falls back to the plain 2K mapping
		load_image(8'd0, 2048);
		read_back(2048, 1'b0);
	endtask

	task automatic test_xrom();
		load_image(8'(`VP_IDX_XROM), `VP_IMG_4K);
		read_back(`VP_IMG_4K, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// Keyboard and joysticks

	// New event by flipping bit 10, pad assumed idle
	task automatic send_key(input logic [8:0] code, input logic pressed,
			input vp_pkg::byte_t exp);
		ps2_key = {~ps2_key[10], pressed, code};
		next_cycle();
		check_bit("key_valid_o", 1'b1, key_valid);
		check_byte("key_ascii_o", exp, key_ascii);
		check_bit("key_released_o", ~pressed, key_released);
		next_cycle();
		check_bit("key_valid_o", 1'b0, key_valid);
	endtask

	task automatic test_ps2_keys();
		send_key(9'h016, 1'b1, "1");
		send_key(9'h045, 1'b1, "0");
		send_key(9'h01C, 1'b1, "a");
		send_key(9'h01A, 1'b1, "z");
		send_key(9'h029, 1'b1, " ");
		send_key(9'h079, 1'b1, "+");
		send_key(9'h07B, 1'b1, "-");
		send_key(9'h07C, 1'b1, "*");
		// Extended keypad slash
		send_key(9'h14A, 1'b1, "/");
		send_key(9'h055, 1'b1, "=");
		send_key(9'h11F, 1'b1, 8'h11);
		send_key(9'h127, 1'b1, 8'h12);
		send_key(9'h15A, 1'b1, 8'h0A);
		send_key(9'h066, 1'b1, 8'h08);
		// Unknown codes, plain and extended
		send_key(9'h076, 1'b1, 8'h00);
		send_key(9'h170, 1'b1, 8'h00);
		send_key(9'h01C, 1'b0, "a");
	endtask

	task automatic check_joy_lines(input vp_pkg::player_pair_t up, input vp_pkg::player_pair_t down,
			input vp_pkg::player_pair_t left, input vp_pkg::player_pair_t right,
			input vp_pkg::player_pair_t action);
		#1;
		check_pair("joy_up_n_o", up, joy_up_n);
		check_pair("joy_down_n_o", down, joy_down_n);
		check_pair("joy_left_n_o", left, joy_left_n);
		check_pair("joy_right_n_o", right, joy_right_n);
		check_pair("joy_action_n_o", action, joy_action_n);
	endtask

	// Pad change gives one event with the lowest held key
	task automatic press_pad(input vp_pkg::joy_t j0, input vp_pkg::joy_t j1,
			input vp_pkg::byte_t exp, input logic exp_released);
		joy0 = j0;
		joy1 = j1;
		next_cycle();
		check_bit("key_valid_o", 1'b1, key_valid);
		check_byte("key_ascii_o", exp, key_ascii);
		check_bit("key_released_o", exp_released, key_released);
		next_cycle();
		check_bit("key_valid_o", 1'b0, key_valid);
	endtask

	task automatic test_joysticks();
		// First player right and down, second player left, up and action
		joy0 = 16'h0005;
		joy1 = 16'h001A;
		swap = 1'b0;
		check_joy_lines(2'b10, 2'b01, 2'b10, 2'b01, 2'b10);
		swap = 1'b1;
		check_joy_lines(2'b01, 2'b10, 2'b01, 2'b10, 2'b01);
		// Console reset needs both players
		joy0 = 16'h0020;
		joy1 = 16'h0000;
		#1;
		check_bit("console_reset_n_o", 1'b1, console_reset_n);
		joy1 = 16'h0020;
		#1;
		check_bit("console_reset_n_o", 1'b0, console_reset_n);
		swap = 1'b0;
		next_cycle();
		// Keys 3 and 6 on different players
		press_pad(16'h0100, 16'h0800, "3", 1'b0);
		press_pad(16'h0000, 16'h0800, "6", 1'b0);
		press_pad(16'h0000, 16'h8000, "0", 1'b0);
		press_pad(16'h0000, 16'h8200, "4", 1'b0);
		// Last PS/2 event was a release
		press_pad(16'h0000, 16'h0000, 8'h00, 1'b1);
		swap = 1'b1;
		press_pad(16'h0040, 16'h0000, "1", 1'b0);
		press_pad(16'h0000, 16'h0000, 8'h00, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		pal = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_index = '0;
		dl_data = '0;
		cart_addr = '0;
		cart_bs0 = 1'b0;
		cart_bs1 = 1'b0;
		cart_psen_n = 1'b1;
		joy0 = '0;
		joy1 = '0;
		swap = 1'b0;
		ps2_key = '0;
		@(negedge reset);
		check_bit("key_valid_o", 1'b0, key_valid);
		test_enables();
		test_4k_image();
		test_large_images();
		test_xrom();
		test_ps2_keys();
		test_joysticks();
		$display("STATUS: PASS");
		$finish;
	end

	// Twice the length of all tests
	initial begin
		repeat (2 * test_cycles) @(posedge clk_sys);
		fail_run("Watchdog expired before the tests finished");
	end

endmodule
